//--- blob_tracker_top.f
+incdir+include
src/tracker_pkg.sv
src/video_timing_gen.sv
src/luma_mask.sv
src/centroid_accumulator.sv
src/serial_divider.sv
src/centroid_fsm.sv
src/crosshair_overlay.sv
src/blob_tracker_top.sv
verification/tb_blob_tracker.sv

//--- src/blob_tracker_top.sv
`timescale 1ns/1ps
`default_nettype none

module blob_tracker_top (
    input wire                          clk_pixel,
    input wire                          recent_reset,
    input wire                          pix_valid_i, // Stream from the CDC FIFO
    input wire [tracker_pkg::PIX_W-1:0] pix_i,
    input wire [tracker_pkg::X_W-1:0]   pix_x_i,
    input wire [tracker_pkg::Y_W-1:0]   pix_y_i,
    input wire [3:0]                    thr_lo_i,
    input wire [3:0]                    thr_hi_i,
    output logic [tracker_pkg::X_W-1:0] cent_x_o,
    output logic [tracker_pkg::Y_W-1:0] cent_y_o,
    output logic                        cent_valid_o,
    output logic [23:0]                 rgb_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        active_o,
    output logic [tracker_pkg::X_W-1:0] hcount_o,
    output logic [tracker_pkg::Y_W-1:0] vcount_o
);
    import tracker_pkg::*;

    logic             mask_valid;
    logic             mask;
    logic [X_W-1:0]   mask_x;
    logic [Y_W-1:0]   mask_y;
    logic             snap;
    logic [SUM_W-1:0] sum_x;
    logic [SUM_W-1:0] sum_y;
    logic [CNT_W-1:0] count;
    logic             div_start;
    logic [SUM_W-1:0] div_dividend;
    logic [CNT_W-1:0] div_divisor;
    logic             div_done;
    logic [SUM_W-1:0] div_quotient;
    logic [X_W-1:0]   raster_h;
    logic [Y_W-1:0]   raster_v;
    logic             raster_hsync;
    logic             raster_vsync;
    logic             raster_active;

    luma_mask i_luma_mask (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .valid_i(pix_valid_i), .pix_i(pix_i), .x_i(pix_x_i), .y_i(pix_y_i),
        .thr_lo_i(thr_lo_i), .thr_hi_i(thr_hi_i),
        .valid_o(mask_valid), .mask_o(mask), .x_o(mask_x), .y_o(mask_y));

    centroid_accumulator i_centroid_accumulator (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .valid_i(mask_valid), .mask_i(mask), .x_i(mask_x), .y_i(mask_y),
        .snap_o(snap), .sum_x_o(sum_x), .sum_y_o(sum_y), .count_o(count));

    centroid_fsm i_centroid_fsm (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .snap_i(snap), .sum_x_i(sum_x), .sum_y_i(sum_y), .count_i(count),
        .done_i(div_done), .quotient_i(div_quotient),
        .start_o(div_start), .dividend_o(div_dividend), .divisor_o(div_divisor),
        .cent_x_o(cent_x_o), .cent_y_o(cent_y_o), .cent_valid_o(cent_valid_o));

    serial_divider i_serial_divider (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .start_i(div_start), .dividend_i(div_dividend), .divisor_i(div_divisor),
        .done_o(div_done), .quotient_o(div_quotient));

    video_timing_gen i_video_timing_gen (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .hcount_o(raster_h), .vcount_o(raster_v),
        .hsync_o(raster_hsync), .vsync_o(raster_vsync), .active_o(raster_active));

    // Display side, one cycle behind the raster
    crosshair_overlay i_crosshair_overlay (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .hcount_i(raster_h), .vcount_i(raster_v),
        .hsync_i(raster_hsync), .vsync_i(raster_vsync), .active_i(raster_active),
        .cent_x_i(cent_x_o), .cent_y_i(cent_y_o), .cent_valid_i(cent_valid_o),
        .rgb_o(rgb_o), .hsync_o(hsync_o), .vsync_o(vsync_o), .active_o(active_o),
        .hcount_o(hcount_o), .vcount_o(vcount_o));

endmodule

`default_nettype wire

//--- src/centroid_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

module centroid_accumulator (
    input wire                            clk_pixel,
    input wire                            recent_reset,
    input wire                            valid_i,
    input wire                            mask_i,
    input wire [tracker_pkg::X_W-1:0]     x_i,
    input wire [tracker_pkg::Y_W-1:0]     y_i,
    output logic                          snap_o,
    output logic [tracker_pkg::SUM_W-1:0] sum_x_o,
    output logic [tracker_pkg::SUM_W-1:0] sum_y_o,
    output logic [tracker_pkg::CNT_W-1:0] count_o
);
    import tracker_pkg::*;

    logic             hit;
    logic             frame_end;
    logic [SUM_W-1:0] add_x;
    logic [SUM_W-1:0] add_y;
    logic [SUM_W-1:0] acc_x;
    logic [SUM_W-1:0] acc_y;
    logic [CNT_W-1:0] acc_cnt;

    assign hit       = valid_i && mask_i;
    assign frame_end = valid_i && (x_i == X_W'(FRAME_W - 1)) && (y_i == Y_W'(FRAME_H - 1));
    assign add_x     = hit ? SUM_W'(x_i) : '0;
    assign add_y     = hit ? SUM_W'(y_i) : '0;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            acc_x   <= '0;
            acc_y   <= '0;
            acc_cnt <= '0;
            snap_o  <= 1'b0;
        end else begin
            snap_o <= frame_end;
            if (frame_end) begin
                // Next frame starts from zero right away
                acc_x   <= '0;
                acc_y   <= '0;
                acc_cnt <= '0;
            end else begin
                acc_x   <= acc_x + add_x;
                acc_y   <= acc_y + add_y;
                acc_cnt <= acc_cnt + CNT_W'(hit);
            end
        end
    end

    // Snapshot includes the frame-end pixel itself
    always_ff @(posedge clk_pixel) begin
        if (frame_end) begin
            sum_x_o <= acc_x + add_x;
            sum_y_o <= acc_y + add_y;
            count_o <= acc_cnt + CNT_W'(hit);
        end
    end

endmodule

`default_nettype wire

//--- src/centroid_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module centroid_fsm (
    input wire                            clk_pixel,
    input wire                            recent_reset,
    input wire                            snap_i,
    input wire [tracker_pkg::SUM_W-1:0]   sum_x_i,
    input wire [tracker_pkg::SUM_W-1:0]   sum_y_i,
    input wire [tracker_pkg::CNT_W-1:0]   count_i,
    input wire                            done_i,
    input wire [tracker_pkg::SUM_W-1:0]   quotient_i,
    output logic                          start_o,
    output logic [tracker_pkg::SUM_W-1:0] dividend_o,
    output logic [tracker_pkg::CNT_W-1:0] divisor_o,
    output logic [tracker_pkg::X_W-1:0]   cent_x_o,
    output logic [tracker_pkg::Y_W-1:0]   cent_y_o,
    output logic                          cent_valid_o
);
    import tracker_pkg::*;

    fsm_state_t       state;
    logic             take_snap;
    logic [SUM_W-1:0] lat_sum_x;
    logic [SUM_W-1:0] lat_sum_y;
    logic [CNT_W-1:0] lat_count;
    logic [X_W-1:0]   quot_x;

    // Empty frames are dropped, the old centroid stays
    assign take_snap = (state == ST_IDLE) && snap_i && (count_i != '0);

    assign dividend_o   = (state == ST_DIV_Y) ? lat_sum_y : lat_sum_x;
    assign divisor_o    = lat_count;
    assign cent_valid_o = (state == ST_PUBLISH);

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            state   <= ST_IDLE;
            start_o <= 1'b0;
        end else begin
            start_o <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (take_snap) begin
                        start_o <= 1'b1;
                        state   <= ST_DIV_X;
                    end
                end
                ST_DIV_X: begin
                    if (done_i) begin
                        start_o <= 1'b1; // Divider is idle again here
                        state   <= ST_DIV_Y;
                    end
                end
                ST_DIV_Y: begin
                    if (done_i) begin
                        state <= ST_PUBLISH;
                    end
                end
                ST_PUBLISH: state <= ST_IDLE;
                default:    state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (take_snap) begin
            lat_sum_x <= sum_x_i;
            lat_sum_y <= sum_y_i;
            lat_count <= count_i;
        end
        if ((state == ST_DIV_X) && done_i) begin
            quot_x <= quotient_i[X_W-1:0]; // Held until y is ready too
        end
        if ((state == ST_DIV_Y) && done_i) begin
            cent_x_o <= quot_x;
            cent_y_o <= quotient_i[Y_W-1:0];
        end
    end

endmodule

`default_nettype wire

//--- src/crosshair_overlay.sv
`timescale 1ns/1ps
`default_nettype none

module crosshair_overlay (
    input wire                          clk_pixel,
    input wire                          recent_reset,
    input wire [tracker_pkg::X_W-1:0]   hcount_i,
    input wire [tracker_pkg::Y_W-1:0]   vcount_i,
    input wire                          hsync_i,
    input wire                          vsync_i,
    input wire                          active_i,
    input wire [tracker_pkg::X_W-1:0]   cent_x_i,
    input wire [tracker_pkg::Y_W-1:0]   cent_y_i,
    input wire                          cent_valid_i,
    output logic [23:0]                 rgb_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        active_o,
    output logic [tracker_pkg::X_W-1:0] hcount_o,
    output logic [tracker_pkg::Y_W-1:0] vcount_o
);
    import tracker_pkg::*;

    logic [X_W-1:0] disp_x;
    logic [Y_W-1:0] disp_y;
    logic           seen;
    logic           on_line;

    assign on_line = active_i && seen && ((hcount_i == disp_x) || (vcount_i == disp_y));

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            seen     <= 1'b0; // Nothing drawn until the first centroid
            rgb_o    <= '0;
            hsync_o  <= 1'b0;
            vsync_o  <= 1'b0;
            active_o <= 1'b0;
        end else begin
            if (cent_valid_i) seen <= 1'b1;
            rgb_o    <= on_line ? 24'hff_ffff : 24'h00_0000;
            hsync_o  <= hsync_i;
            vsync_o  <= vsync_i;
            active_o <= active_i;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (cent_valid_i) begin
            disp_x <= cent_x_i;
            disp_y <= cent_y_i;
        end
        hcount_o <= hcount_i; // Keep coordinates aligned with rgb_o
        vcount_o <= vcount_i;
    end

endmodule

`default_nettype wire

//--- src/luma_mask.sv
`timescale 1ns/1ps
`default_nettype none

module luma_mask (
    input wire                            clk_pixel,
    input wire                            recent_reset,
    input wire                            valid_i,
    input wire [tracker_pkg::PIX_W-1:0]   pix_i,
    input wire [tracker_pkg::X_W-1:0]     x_i,
    input wire [tracker_pkg::Y_W-1:0]     y_i,
    input wire [3:0]                      thr_lo_i,
    input wire [3:0]                      thr_hi_i,
    output logic                          valid_o,
    output logic                          mask_o,
    output logic [tracker_pkg::X_W-1:0]   x_o,
    output logic [tracker_pkg::Y_W-1:0]   y_o
);
    import tracker_pkg::*;

    logic [7:0]     red8;
    logic [7:0]     green8;
    logic [7:0]     blue8;
    logic [15:0]    luma_sum;
    logic [7:0]     luma_q;
    logic           valid_q;
    logic [X_W-1:0] x_q;
    logic [Y_W-1:0] y_q;

    // Expand to 8 bits per channel, low bits zero
    assign red8   = {pix_i[15:11], 3'b000};
    assign green8 = {pix_i[10:5], 2'b00};
    assign blue8  = {pix_i[4:0], 3'b000};

    assign luma_sum = red8 * LUMA_R + green8 * LUMA_G + blue8 * LUMA_B;

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            valid_q <= 1'b0;
            valid_o <= 1'b0;
        end else begin
            valid_q <= valid_i;
            valid_o <= valid_q;
        end
    end

    always_ff @(posedge clk_pixel) begin
        luma_q <= luma_sum[15:8]; // Stage 1
        x_q    <= x_i;
        y_q    <= y_i;
        // Stage 2, window is (lo, hi]
        mask_o <= (luma_q > {thr_lo_i, 4'b0000}) && (luma_q <= {thr_hi_i, 4'b1111});
        x_o    <= x_q;
        y_o    <= y_q;
    end

endmodule

`default_nettype wire

//--- src/serial_divider.sv
`timescale 1ns/1ps
`default_nettype none

module serial_divider (
    input wire                            clk_pixel,
    input wire                            recent_reset,
    input wire                            start_i,
    input wire [tracker_pkg::SUM_W-1:0]   dividend_i,
    input wire [tracker_pkg::CNT_W-1:0]   divisor_i,
    output logic                          done_o,
    output logic [tracker_pkg::SUM_W-1:0] quotient_o
);
    import tracker_pkg::*;

    logic                 busy;
    logic                 load;
    logic [DIV_CNT_W-1:0] bit_cnt;
    logic [CNT_W-1:0]     divisor_q;
    logic [CNT_W-1:0]     rem;
    logic [CNT_W:0]       rem_shift;
    logic [CNT_W:0]       rem_diff;
    logic                 fits;

    assign load = start_i && !busy; // Start is only taken when idle

    // Quotient register doubles as the dividend shifter
    assign rem_shift = {rem, quotient_o[SUM_W-1]};
    assign rem_diff  = rem_shift - {1'b0, divisor_q};
    assign fits      = (rem_shift >= {1'b0, divisor_q});

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            busy    <= 1'b0;
            done_o  <= 1'b0;
            bit_cnt <= '0;
        end else begin
            done_o <= 1'b0;
            if (load) begin
                busy    <= 1'b1;
                bit_cnt <= DIV_CNT_W'(SUM_W - 1);
            end else if (busy) begin
                if (bit_cnt == '0) begin
                    busy   <= 1'b0;
                    done_o <= 1'b1; // Last quotient bit lands with done
                end else begin
                    bit_cnt <= bit_cnt - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (load) begin
            quotient_o <= dividend_i;
            rem        <= '0;
            divisor_q  <= divisor_i;
        end else if (busy) begin
            // Restore by keeping the unsubtracted value
            rem        <= fits ? rem_diff[CNT_W-1:0] : rem_shift[CNT_W-1:0];
            quotient_o <= {quotient_o[SUM_W-2:0], fits};
        end
    end

endmodule

`default_nettype wire

//--- src/tracker_pkg.sv
`default_nettype none

package tracker_pkg;

    // Active area, shared by camera frames and the display
    localparam int FRAME_W = 64;
    localparam int FRAME_H = 36;

    // Horizontal blanking in clocks
    localparam int H_FRONT = 4;
    localparam int H_SYNC  = 8;
    localparam int H_BACK  = 8;

    // Vertical blanking in lines
    localparam int V_FRONT = 2;
    localparam int V_SYNC  = 2;
    localparam int V_BACK  = 3;

    localparam int H_TOTAL = FRAME_W + H_FRONT + H_SYNC + H_BACK; // 84 clocks per line
    localparam int V_TOTAL = FRAME_H + V_FRONT + V_SYNC + V_BACK; // 43 lines per frame

    localparam int X_W       = 7;  // Covers H_TOTAL
    localparam int Y_W       = 6;  // Covers V_TOTAL
    localparam int PIX_W     = 16; // RGB565
    localparam int CNT_W     = 12; // Masked pixels per frame
    localparam int SUM_W     = 18; // Coordinate sums
    localparam int DIV_CNT_W = $clog2(SUM_W);

    // Luma weights, sum is shifted right by 8 afterwards
    localparam logic [7:0] LUMA_R = 8'd77;
    localparam logic [7:0] LUMA_G = 8'd150;
    localparam logic [7:0] LUMA_B = 8'd29;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_DIV_X,
        ST_DIV_Y,
        ST_PUBLISH
    } fsm_state_t;

endpackage

`default_nettype wire

//--- src/video_timing_gen.sv
`timescale 1ns/1ps
`default_nettype none

module video_timing_gen (
    input wire                          clk_pixel,
    input wire                          recent_reset,
    output logic [tracker_pkg::X_W-1:0] hcount_o,
    output logic [tracker_pkg::Y_W-1:0] vcount_o,
    output logic                        hsync_o,
    output logic                        vsync_o,
    output logic                        active_o
);
    import tracker_pkg::*;

    logic h_last;
    logic v_last;

    assign h_last = (hcount_o == X_W'(H_TOTAL - 1));
    assign v_last = (vcount_o == Y_W'(V_TOTAL - 1));

    // Free-running raster, one position per clock
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount_o <= '0;
            vcount_o <= '0;
        end else if (h_last) begin
            hcount_o <= '0;
            vcount_o <= v_last ? '0 : vcount_o + 1'b1; // Wrap at frame end
        end else begin
            hcount_o <= hcount_o + 1'b1;
        end
    end

    // Sync pulses sit right after the front porch
    assign hsync_o = (hcount_o >= X_W'(FRAME_W + H_FRONT)) &&
                     (hcount_o <  X_W'(FRAME_W + H_FRONT + H_SYNC));
    assign vsync_o = (vcount_o >= Y_W'(FRAME_H + V_FRONT)) &&
                     (vcount_o <  Y_W'(FRAME_H + V_FRONT + V_SYNC));

    assign active_o = (hcount_o < X_W'(FRAME_W)) && (vcount_o < Y_W'(FRAME_H));

endmodule

`default_nettype wire

//--- include/tb_frame_model.svh
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// Expected centroids in publish order
int exp_x_q[$];
int exp_y_q[$];

// Luma of an RGB565 word with channels widened by zero low bits
function automatic int luma_of(input logic [15:0] pix);
    int r8;
    int g8;
    int b8;
    r8 = int'(pix[15:11]) * 8;
    g8 = int'(pix[10:5]) * 4;
    b8 = int'(pix[4:0]) * 8;
    return (r8 * 77 + g8 * 150 + b8 * 29) / 256;
endfunction

// Target window is (lo, hi] on the 8-bit luma scale
function automatic bit in_window(input logic [15:0] pix, input int lo, input int hi);
    int luma;
    luma = luma_of(pix);
    return (luma > lo * 16) && (luma <= hi * 16 + 15);
endfunction

function automatic int centroid_of(input int sum, input int count);
    return sum / count; // Integer division floors because sums are never negative
endfunction

// First RGB565 word with the requested luma or -1 if there is none
function automatic int pix_with_luma(input int target);
    for (int p = 0; p < 65536; p++) begin
        if (luma_of(16'(p)) == target) return p;
    end
    return -1;
endfunction

`endif

//--- verification/tb_blob_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_blob_tracker;
    import tracker_pkg::*;

    localparam real CLK_PERIOD   = 8.0;
    localparam int  NUM_FRAMES   = 6;
    localparam int  INTER_GAP    = 64;
    localparam int  FRAME_CYCLES = 2 * FRAME_W * FRAME_H + INTER_GAP; // At most one gap per pixel
    localparam real WATCHDOG_NS  = (NUM_FRAMES * FRAME_CYCLES + H_TOTAL * V_TOTAL) * 2 * CLK_PERIOD;

    logic             clk_pixel;
    logic             recent_reset;
    logic             pix_valid_i;
    logic [PIX_W-1:0] pix_i;
    logic [X_W-1:0]   pix_x_i;
    logic [Y_W-1:0]   pix_y_i;
    logic [3:0]       thr_lo_i;
    logic [3:0]       thr_hi_i;
    logic [X_W-1:0]   cent_x_o;
    logic [Y_W-1:0]   cent_y_o;
    logic             cent_valid_o;
    logic [23:0]      rgb_o;
    logic             hsync_o;
    logic             vsync_o;
    logic             active_o;
    logic [X_W-1:0]   hcount_o;
    logic [Y_W-1:0]   vcount_o;

    logic [15:0] frame_pix [FRAME_W*FRAME_H];
    int          settle;
    bit          seen_use;
    bit          seen_pend;
    int          dx_use;
    int          dy_use;
    int          dx_pend;
    int          dy_pend;
    int          exp_x;
    int          exp_y;
    int          prev_h;
    int          prev_v;
    bit          have_prev;
    bit          act_exp;
    logic [23:0] rgb_exp;

    `include "tb_frame_model.svh"

    blob_tracker_top i_blob_tracker_top (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .pix_valid_i(pix_valid_i), .pix_i(pix_i), .pix_x_i(pix_x_i), .pix_y_i(pix_y_i),
        .thr_lo_i(thr_lo_i), .thr_hi_i(thr_hi_i),
        .cent_x_o(cent_x_o), .cent_y_o(cent_y_o), .cent_valid_o(cent_valid_o),
        .rgb_o(rgb_o), .hsync_o(hsync_o), .vsync_o(vsync_o), .active_o(active_o),
        .hcount_o(hcount_o), .vcount_o(vcount_o));

    always #(CLK_PERIOD / 2) clk_pixel = ~clk_pixel;

    task automatic stop_failed();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("** Error at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
            stop_failed();
        end
    endtask

    task automatic clear_frame();
        foreach (frame_pix[i]) frame_pix[i] = 16'h0000;
    endtask

    // Random colors scattered over a square around a random center
    task automatic build_blob_frame();
        int cx;
        int cy;
        int r;
        clear_frame();
        cx = $urandom_range(FRAME_W - 9, 8);
        cy = $urandom_range(FRAME_H - 7, 6);
        r  = $urandom_range(6, 3);
        for (int y = cy - r; y <= cy + r; y++) begin
            for (int x = cx - r; x <= cx + r; x++) begin
                if ($urandom_range(1) == 1) frame_pix[y * FRAME_W + x] = 16'($urandom());
            end
        end
    endtask

    // Pixels just inside and just outside both edges of the window (64, 159]
    task automatic build_boundary_frame();
        int p_lo;
        int p_in_lo;
        int p_hi;
        int p_out_hi;
        clear_frame();
        p_lo     = pix_with_luma(64);
        p_in_lo  = pix_with_luma(65);
        p_hi     = pix_with_luma(159);
        p_out_hi = pix_with_luma(160);
        if (p_lo < 0 || p_in_lo < 0 || p_hi < 0 || p_out_hi < 0) begin
            $display("No RGB565 word reaches one of the boundary luma values");
            stop_failed();
        end
        for (int i = 0; i < 4; i++) begin
            frame_pix[2 * FRAME_W + 2 + i]    = 16'(p_lo);     // Lower edge itself is no target
            frame_pix[10 * FRAME_W + 20 + i]  = 16'(p_in_lo);
            frame_pix[(20 + i) * FRAME_W + 40] = 16'(p_hi);    // Upper edge is still a target
            frame_pix[33 * FRAME_W + 60 - i]  = 16'(p_out_hi);
        end
    endtask

    // Queue the expected centroid and stream the frame with random gaps
    task automatic run_frame(input int lo, input int hi);
        int sum_x;
        int sum_y;
        int count;
        sum_x = 0;
        sum_y = 0;
        count = 0;
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                if (in_window(frame_pix[y * FRAME_W + x], lo, hi)) begin
                    sum_x += x;
                    sum_y += y;
                    count++;
                end
            end
        end
        if (count != 0) begin
            exp_x_q.push_back(centroid_of(sum_x, count));
            exp_y_q.push_back(centroid_of(sum_y, count));
        end
        thr_lo_i <= 4'(lo);
        thr_hi_i <= 4'(hi);
        for (int y = 0; y < FRAME_H; y++) begin
            for (int x = 0; x < FRAME_W; x++) begin
                if ($urandom_range(3) == 0) begin
                    pix_valid_i <= 1'b0;
                    @(posedge clk_pixel);
                end
                pix_valid_i <= 1'b1;
                pix_i       <= frame_pix[y * FRAME_W + x];
                pix_x_i     <= X_W'(x);
                pix_y_i     <= Y_W'(y);
                @(posedge clk_pixel);
            end
        end
        pix_valid_i <= 1'b0;
        repeat (INTER_GAP) @(posedge clk_pixel);
    endtask

    // Outputs are sampled on the falling edge
    always @(negedge clk_pixel) begin
        if (recent_reset) begin
            settle = 0;
        end else if (settle < 2) begin
            settle++;
        end
        if (settle == 2) begin
            if (have_prev) begin
                check_value("hcount_o", hcount_o, (prev_h + 1) % H_TOTAL);
                check_value("vcount_o", vcount_o,
                            (prev_h == H_TOTAL - 1) ? (prev_v + 1) % V_TOTAL : prev_v);
            end
            prev_h    = hcount_o;
            prev_v    = vcount_o;
            have_prev = 1'b1;
            act_exp   = (hcount_o < FRAME_W) && (vcount_o < FRAME_H);
            check_value("active_o", active_o, act_exp);
            check_value("hsync_o", hsync_o, (hcount_o >= FRAME_W + H_FRONT) &&
                                            (hcount_o < FRAME_W + H_FRONT + H_SYNC));
            check_value("vsync_o", vsync_o, (vcount_o >= FRAME_H + V_FRONT) &&
                                            (vcount_o < FRAME_H + V_FRONT + V_SYNC));
            rgb_exp = (act_exp && seen_use && (hcount_o == dx_use || vcount_o == dy_use)) ?
                      24'hff_ffff : 24'h00_0000;
            check_value("rgb_o", rgb_o, rgb_exp);
            // Overlay draws a new centroid two cycles after the pulse
            seen_use = seen_pend;
            dx_use   = dx_pend;
            dy_use   = dy_pend;
            if (cent_valid_o) begin
                if (exp_x_q.size() == 0) begin
                    $display("Centroid published at %0t with no frame expecting one", $time);
                    stop_failed();
                end
                exp_x = exp_x_q.pop_front();
                exp_y = exp_y_q.pop_front();
                check_value("cent_x_o", cent_x_o, exp_x);
                check_value("cent_y_o", cent_y_o, exp_y);
                seen_pend = 1'b1;
                dx_pend   = exp_x;
                dy_pend   = exp_y;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout, the run did not finish by %0t", $time);
        stop_failed();
    end

    initial begin
        void'($urandom(32'h9c69_1af3));
        clk_pixel    = 1'b0;
        recent_reset = 1'b1;
        pix_valid_i  = 1'b0;
        pix_i        = '0;
        pix_x_i      = '0;
        pix_y_i      = '0;
        thr_lo_i     = 4'd4;
        thr_hi_i     = 4'd15;
        settle       = 0;
        seen_use     = 1'b0;
        seen_pend    = 1'b0;
        have_prev    = 1'b0;
        repeat (10) @(posedge clk_pixel);
        recent_reset <= 1'b0;
        repeat (4) @(posedge clk_pixel);
        repeat (2) begin
            build_blob_frame();
            run_frame(4, 15);
        end
        clear_frame();
        run_frame(4, 15);           // Black frame publishes nothing
        build_boundary_frame();
        run_frame(4, 9);
        run_frame(2, 12);           // Same pixels in a wider window
        build_blob_frame();
        run_frame(4, 15);
        for (int i = 0; i < 4 * SUM_W + 16 && exp_x_q.size() != 0; i++) begin
            @(posedge clk_pixel);
        end
        repeat (H_TOTAL * V_TOTAL) @(posedge clk_pixel); // Full display frame with the last crosshair
        if (exp_x_q.size() != 0) begin
            $display("%0d expected centroids were never published", exp_x_q.size());
            stop_failed();
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire
